// ==== build.f ====
hdl/periph_pkg.sv
hdl/select_cell.sv
hdl/select_unit.sv
hdl/int_controller.sv
hdl/shadow_ram.sv
hdl/periph_top.sv
test/periph_top_props.sv
test/tb_periph_top.sv

// ==== hdl/int_controller.sv ====
`timescale 1ns/1ps

module int_controller (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [2:0]            reg_addr,
   input  periph_pkg::bus_data_t wdata,
   input  logic                  read,
   input  logic                  write,
   input  logic                  select,
   input  logic                  inta,
   input  periph_pkg::irq_vec_t  irq_lines,
   output periph_pkg::bus_data_t rdata,
   output logic                  intr
);

   import periph_pkg::*;

   irq_vec_t   mask_q;       // 1 enables the line
   irq_vec_t   active_q;     // latched requests
   irq_vec_t   polarity_q;   // level, or level after the edge
   irq_vec_t   edge_q;       // 1 edge mode, 0 level mode
   bus_data_t  vbase_q;      // vector page
   irq_vec_t   irq_prev;     // lines one clock earlier
   irq_vec_t   trig_q;       // triggers sampled last edge
   irq_vec_t   trig_now;
   irq_vec_t   rise;
   irq_vec_t   fall;
   irq_vec_t   service_bit;  // one hot, highest priority active line
   logic [2:0] prio_idx;
   vec_state_t vec_state;
   logic       reg_write;

   assign reg_write = write && select;

   ////////////////////////////////////////
   // trigger detection
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      irq_prev <= irq_lines;   // plain sampler for edge compare
   end

   assign rise = irq_lines & ~irq_prev;
   assign fall = ~irq_lines & irq_prev;

   assign trig_now = mask_q & ((~(irq_lines ^ polarity_q) & ~edge_q)   // level match
                             | (rise & polarity_q & edge_q)           // rising edge
                             | (fall & ~polarity_q & edge_q));        // falling edge

   always_ff @(posedge clock) begin
      if (reset) begin
         trig_q <= '0;
      end else begin
         trig_q <= trig_now;
      end
   end

   ////////////////////////////////////////
   // priority, line 0 wins
   ////////////////////////////////////////

   assign service_bit = active_q & (~active_q + 8'd1);   // lowest set bit

   always_comb begin
      prio_idx = '0;
      for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
         if (active_q[i]) prio_idx = 3'(i);   // last hit is lowest index
      end
   end

   // control registers
   always_ff @(posedge clock) begin
      if (reset) begin
         mask_q     <= '0;
         polarity_q <= '0;
         edge_q     <= '0;
         vbase_q    <= '0;
      end else if (reg_write) begin
         case (reg_addr)
            INT_REG_MASK:     mask_q     <= wdata;
            INT_REG_POLARITY: polarity_q <= wdata;
            INT_REG_EDGE:     edge_q     <= wdata;
            INT_REG_BASE:     vbase_q    <= wdata;
            default: ;   // status is read only, active handled below
         endcase
      end
   end

   // active bits, set by triggers or software, cleared on service
   always_ff @(posedge clock) begin
      if (reset) begin
         active_q <= '0;
      end else if (reg_write && reg_addr == INT_REG_ACTIVE) begin
         active_q <= wdata | trig_q;    // pending trigger not lost
      end else if (inta && vec_state == VEC_HIGH) begin
         active_q <= (active_q & ~service_bit) | trig_q;
      end else begin
         active_q <= active_q | trig_q;
      end
   end

   ////////////////////////////////////////
   // vectoring and read data
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         vec_state <= VEC_CALL;
      end else if (inta) begin
         case (vec_state)
            VEC_CALL: vec_state <= VEC_LOW;
            VEC_LOW:  vec_state <= VEC_HIGH;
            default:  vec_state <= VEC_CALL;   // sequence done
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         rdata <= '0;
      end else if (read && select) begin
         case (reg_addr)
            INT_REG_MASK:     rdata <= mask_q;
            INT_REG_STATUS:   rdata <= irq_lines;   // live, not latched
            INT_REG_ACTIVE:   rdata <= active_q;
            INT_REG_POLARITY: rdata <= polarity_q;
            INT_REG_EDGE:     rdata <= edge_q;
            INT_REG_BASE:     rdata <= vbase_q;
            default:          rdata <= '0;
         endcase
      end else if (inta) begin
         case (vec_state)
            VEC_CALL: rdata <= CALL_OPCODE;
            VEC_LOW:  rdata <= bus_data_t'(prio_idx) * bus_data_t'(VECTOR_STRIDE);
            default:  rdata <= vbase_q;
         endcase
      end else begin
         rdata <= '0;
      end
   end

   assign intr = |active_q;   // any active line requests

endmodule

// ==== hdl/periph_pkg.sv ====
package periph_pkg;

   ////////////////////////////////////////
   // bus and register types
   ////////////////////////////////////////

   typedef logic [15:0] bus_addr_t;   // cpu address
   typedef logic [7:0]  bus_data_t;   // cpu data byte
   typedef logic [9:0]  ram_addr_t;   // shadow ram word address
   typedef logic [7:0]  irq_vec_t;    // one bit per interrupt line
   typedef logic [3:0]  sel_vec_t;    // bit 0 is select 1
   typedef logic [5:0]  match_t;      // select cell mask or compare field

   // three byte call sequence on inta
   typedef enum logic [1:0] {
      VEC_CALL,    // call opcode
      VEC_LOW,     // low byte, line times stride
      VEC_HIGH     // high byte, vector base
   } vec_state_t;

   ////////////////////////////////////////
   // sizes and constants
   ////////////////////////////////////////

   localparam int SEL_COUNT = 4;         // select cells in the unit
   localparam int RAM_DEPTH = 1024;      // bytes of shadow ram

   localparam bus_data_t CALL_OPCODE = 8'hCD;   // 8080 call
   localparam int VECTOR_STRIDE = 4;            // bytes per vector slot

   // interrupt controller register offsets
   localparam logic [2:0] INT_REG_MASK     = 3'd0;
   localparam logic [2:0] INT_REG_STATUS   = 3'd1;  // live lines, read only
   localparam logic [2:0] INT_REG_ACTIVE   = 3'd2;
   localparam logic [2:0] INT_REG_POLARITY = 3'd3;
   localparam logic [2:0] INT_REG_EDGE     = 3'd4;
   localparam logic [2:0] INT_REG_BASE     = 3'd5;  // vector page

   // select unit register slots, slot is addr[3:1]
   // slot 0 is the main register, slot n holds cell n
   // (mask at offset 2n, compare at 2n+1)
   localparam logic [2:0] SEL_REG_MAIN = 3'd0;

endpackage

// ==== hdl/periph_top.sv ====
`timescale 1ns/1ps

module periph_top (
   input  logic                  clock,
   input  logic                  reset,
   input  periph_pkg::bus_addr_t addr,
   input  periph_pkg::bus_data_t wdata,
   input  logic                  readmem,
   input  logic                  writemem,
   input  logic                  readio,
   input  logic                  writeio,
   input  logic                  inta,
   input  periph_pkg::irq_vec_t  irq_lines,
   output periph_pkg::bus_data_t rdata,
   output logic                  intr,
   output periph_pkg::sel_vec_t  sel,
   output logic                  bootstrap
);

   import periph_pkg::*;

   bus_data_t sel_rdata;   // selector registers
   bus_data_t int_rdata;   // interrupt controller, incl. vector bytes
   bus_data_t ram_rdata;   // shadow ram

   ////////////////////////////////////////
   // address select unit, always in i/o
   ////////////////////////////////////////

   select_unit u_select (
      .clock     (clock),
      .reset     (reset),
      .addr      (addr),
      .wdata     (wdata),
      .readio    (readio),
      .writeio   (writeio),
      .rdata     (sel_rdata),
      .sel       (sel),
      .bootstrap (bootstrap)
   );

   // interrupt controller on select 3, i/o mapped
   int_controller u_intc (
      .clock     (clock),
      .reset     (reset),
      .reg_addr  (addr[2:0]),
      .wdata     (wdata),
      .read      (readio),
      .write     (writeio),
      .select    (sel[2]),
      .inta      (inta),
      .irq_lines (irq_lines),
      .rdata     (int_rdata),
      .intr      (intr)
   );

   // ram on select 2, memory mapped
   shadow_ram u_ram (
      .clock     (clock),
      .addr      (addr[9:0]),
      .wdata     (wdata),
      .select    (sel[1]),
      .read      (readmem),
      .write     (writemem),
      .bootstrap (bootstrap),
      .rdata     (ram_rdata)
   );

   // idle responders return zero
   assign rdata = sel_rdata | int_rdata | ram_rdata;

endmodule

// ==== hdl/select_cell.sv ====
`timescale 1ns/1ps

module select_cell (
   input  logic                  clock,
   input  logic                  reset,
   input  periph_pkg::bus_addr_t addr,
   input  periph_pkg::bus_data_t wdata,
   input  logic                  access,   // this cell's register pair addressed
   input  logic                  write,
   input  logic                  read,
   output periph_pkg::bus_data_t rdata,
   output logic                  hit
);

   import periph_pkg::*;

   // mask byte layout
   //   7:2 mask field, 1 i/o space, 0 enable
   bus_data_t mask_q;
   match_t    comp_q;     // compare field, low two bits read back as zero
   match_t    addr_field; // address bits under test
   logic      is_io;
   logic      enable;

   assign is_io  = mask_q[1];
   assign enable = mask_q[0];

   ////////////////////////////////////////
   // register access
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         mask_q <= '0;   // cell disabled after reset
         comp_q <= '0;
      end else if (access && write) begin
         if (addr[0]) begin
            comp_q <= wdata[7:2];
         end else begin
            mask_q <= wdata;
         end
      end
   end

   // read byte held for one cycle, zero when not answering
   always_ff @(posedge clock) begin
      if (reset) begin
         rdata <= '0;
      end else if (access && read) begin
         rdata <= addr[0] ? {comp_q, 2'b00} : mask_q;
      end else begin
         rdata <= '0;
      end
   end

   ////////////////////////////////////////
   // address match
   ////////////////////////////////////////

   // i/o space uses low byte, memory uses 1k blocks
   assign addr_field = is_io ? addr[7:2] : addr[15:10];

   // compare is not masked, unmatched pattern bits never hit
   assign hit = enable && ((addr_field & mask_q[7:2]) == comp_q);

endmodule

// ==== hdl/select_unit.sv ====
`timescale 1ns/1ps

module select_unit (
   input  logic                  clock,
   input  logic                  reset,
   input  periph_pkg::bus_addr_t addr,
   input  periph_pkg::bus_data_t wdata,
   input  logic                  readio,
   input  logic                  writeio,
   output periph_pkg::bus_data_t rdata,
   output periph_pkg::sel_vec_t  sel,
   output logic                  bootstrap
);

   import periph_pkg::*;

   logic [3:0] base_q;        // i/o window of the selector, addr[7:4]
   logic       window_hit;    // addr inside our 16 byte window
   logic       main_access;
   bus_data_t  main_rdata;
   bus_data_t  cell_rdata [SEL_COUNT];
   bus_data_t  cells_or;
   sel_vec_t   cell_hit;

   assign window_hit  = (addr[7:4] == base_q);
   assign main_access = window_hit && (addr[3:1] == SEL_REG_MAIN);

   ////////////////////////////////////////
   // main control register
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         base_q    <= '0;     // selector at i/o 0x00
         bootstrap <= 1'b1;   // shadow mode until software clears it
      end else if (writeio && main_access) begin
         base_q    <= wdata[7:4];  // new window from next access on
         bootstrap <= wdata[0];
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         main_rdata <= '0;
      end else if (readio && main_access) begin
         main_rdata <= {base_q, 4'b0000};   // bootstrap bit not readable
      end else begin
         main_rdata <= '0;
      end
   end

   ////////////////////////////////////////
   // select cells, cell i sits at slot i+1
   ////////////////////////////////////////

   for (genvar i = 0; i < SEL_COUNT; i++) begin : g_cell
      localparam logic [2:0] SLOT = 3'(i + 1);

      select_cell u_cell (
         .clock  (clock),
         .reset  (reset),
         .addr   (addr),
         .wdata  (wdata),
         .access (window_hit && (addr[3:1] == SLOT)),
         .write  (writeio),
         .read   (readio),
         .rdata  (cell_rdata[i]),
         .hit    (cell_hit[i])
      );
   end

   // only the addressed cell returns nonzero
   always_comb begin
      cells_or = main_rdata;
      for (int i = 0; i < SEL_COUNT; i++) begin
         cells_or = cells_or | cell_rdata[i];
      end
   end

   assign rdata = cells_or;

   // bootstrap forces rom and ram selects on
   assign sel = cell_hit | {2'b00, bootstrap, bootstrap};

endmodule

// ==== hdl/shadow_ram.sv ====
`timescale 1ns/1ps

module shadow_ram (
   input  logic                  clock,
   input  periph_pkg::ram_addr_t addr,
   input  periph_pkg::bus_data_t wdata,
   input  logic                  select,
   input  logic                  read,
   input  logic                  write,
   input  logic                  bootstrap,   // suppress reads in shadow mode
   output periph_pkg::bus_data_t rdata
);

   import periph_pkg::*;

   bus_data_t mem [RAM_DEPTH];   // ram store
   logic      rd_en;

   // reads blocked while the missing rom owns the bus
   assign rd_en = select && read && !bootstrap;

   ////////////////////////////////////////
   // write port, also active in bootstrap
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (select && write) begin
         mem[addr] <= wdata;
      end
   end

   ////////////////////////////////////////
   // read port
   ////////////////////////////////////////

   // zero outside a read so the top level can or the bytes
   always_ff @(posedge clock) begin
      if (rd_en) begin
         rdata <= mem[addr];
      end else begin
         rdata <= '0;   // also zero for bootstrap reads
      end
   end

endmodule

// ==== run.sh ====
#!/bin/bash
# build and run the peripheral regression with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f build.f \
   --top-module tb_periph_top \
   -Mdir obj_dir \
   && ./obj_dir/Vtb_periph_top | tee /dev/stderr | grep -qx "Regression passed" \
   && exit 0 \
   || exit 1

// ==== test/periph_top_props.sv ====
`timescale 1ns/1ps

module periph_top_props (
   input logic                   clock,
   input logic                   reset,
   input logic                   intr,
   input logic                   bootstrap,
   input logic                   inta,
   input logic                   readmem,
   input logic                   readio,
   input periph_pkg::irq_vec_t   trig,
   input periph_pkg::vec_state_t vec_state,
   input periph_pkg::bus_data_t  rdata
);

   import periph_pkg::*;

   // a pending trigger raises the request on the next edge
   a_intr : assert property (@(posedge clock) disable iff (reset) (|trig) |=> intr)
      else $error("intr did not follow a pending trigger");

   a_boot : assert property (@(posedge clock) $fell(reset) |-> bootstrap)
      else $error("bootstrap low after reset");

   // third pulse closes the sequence
   a_vec : assert property (@(posedge clock) disable iff (reset)
                            (inta && vec_state == VEC_HIGH) |=> vec_state == VEC_CALL)
      else $error("vector state did not return to call");

   a_rdata : assert property (@(posedge clock) disable iff (reset)
                              !$past(readmem || readio || inta) |-> rdata == '0)
      else $error("rdata nonzero without a read");

endmodule

bind periph_top periph_top_props u_props (
   .clock     (clock),
   .reset     (reset),
   .intr      (intr),
   .bootstrap (bootstrap),
   .inta      (inta),
   .readmem   (readmem),
   .readio    (readio),
   .trig      (u_intc.trig_q),
   .vec_state (u_intc.vec_state),
   .rdata     (rdata)
);

// ==== test/tb_periph_top.sv ====
`timescale 1ns/1ps

module tb_periph_top;

   import periph_pkg::*;

   localparam int MAX_CYCLES = 20000;   // far above the length of all tests

   logic      clock;
   logic      reset;
   bus_addr_t addr;
   bus_data_t wdata;
   logic      readmem;
   logic      writemem;
   logic      readio;
   logic      writeio;
   logic      inta;
   irq_vec_t  irq_lines;
   bus_data_t rdata;
   logic      intr;
   sel_vec_t  sel;
   logic      bootstrap;

   int seed = 78;
   int cycles = 0;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int failed_tests = 0;
   int test_start_errors = 0;

   // reference model
   bus_data_t m_mem [RAM_DEPTH];
   bit        m_known [RAM_DEPTH];  // address already listed in m_written
   ram_addr_t m_written [$];      // ram addresses holding known data
   bus_data_t m_mask [SEL_COUNT];
   match_t    m_comp [SEL_COUNT];
   logic      m_boot;

   periph_top UUT (
      .clock     (clock),
      .reset     (reset),
      .addr      (addr),
      .wdata     (wdata),
      .readmem   (readmem),
      .writemem  (writemem),
      .readio    (readio),
      .writeio   (writeio),
      .inta      (inta),
      .irq_lines (irq_lines),
      .rdata     (rdata),
      .intr      (intr),
      .sel       (sel),
      .bootstrap (bootstrap)
   );

   always #4 clock = ~clock;   // 8 ns period

   // run limit
   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, sequence did not finish", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic check_data(string name, bus_data_t exp, bus_data_t act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_sel(string name, sel_vec_t exp, sel_vec_t act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic end_test(string name);
      tests++;
      if (errors != test_start_errors) failed_tests++;
      $display("test %s %s (%0d errors)", name,
               (errors == test_start_errors) ? "ok" : "bad", errors - test_start_errors);
      test_start_errors = errors;
   endtask

   ////////////////////////////////////////
   // cpu bus cycles
   ////////////////////////////////////////

   task automatic io_write(bus_addr_t a, bus_data_t d);
      @(negedge clock);
      addr = a;
      wdata = d;
      writeio = 1'b1;
      @(negedge clock);
      writeio = 1'b0;
   endtask

   task automatic io_read(bus_addr_t a, output bus_data_t d);
      @(negedge clock);
      addr = a;
      readio = 1'b1;
      @(negedge clock);
      readio = 1'b0;
      d = rdata;   // registered at the edge in between
   endtask

   task automatic mem_write(bus_addr_t a, bus_data_t d);
      @(negedge clock);
      addr = a;
      wdata = d;
      writemem = 1'b1;
      @(negedge clock);
      writemem = 1'b0;
   endtask

   task automatic mem_read(bus_addr_t a, output bus_data_t d);
      @(negedge clock);
      addr = a;
      readmem = 1'b1;
      @(negedge clock);
      readmem = 1'b0;
      d = rdata;
   endtask

   task automatic acknowledge(output bus_data_t d);
      @(negedge clock);
      inta = 1'b1;
      @(negedge clock);
      inta = 1'b0;
      d = rdata;
   endtask

   task automatic idle(int n);
      repeat (n) @(negedge clock);
   endtask

   // each written address listed once
   task automatic model_write(ram_addr_t a, bus_data_t d);
      if (!m_known[a]) begin
         m_written.push_back(a);
         m_known[a] = 1'b1;
      end
      m_mem[a] = d;
   endtask

   // enabled cell hits when the masked address field equals compare
   function automatic sel_vec_t sel_model(bus_addr_t a);
      sel_vec_t s;
      match_t   field;
      for (int i = 0; i < SEL_COUNT; i++) begin
         field = m_mask[i][1] ? a[7:2] : a[15:10];   // i/o or 1k memory block
         s[i] = m_mask[i][0] && ((field & m_mask[i][7:2]) == m_comp[i]);
      end
      s[0] = s[0] | m_boot;
      s[1] = s[1] | m_boot;
      return s;
   endfunction

   // silence the interrupt controller and clear active
   task automatic clear_int();
      io_write(16'h0080, 8'h00);
      idle(3);                     // let old triggers drain
      io_write(16'h0082, 8'h00);
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      bus_data_t d;
      bus_data_t v;
      bus_addr_t a;
      irq_vec_t  e;
      irq_vec_t  p;
      irq_vec_t  m;
      irq_vec_t  l0;
      irq_vec_t  l1;
      irq_vec_t  act;
      int        r;
      int        idx;
      int        order [SEL_COUNT] = '{0, 1, 3, 2};   // cell 3 enabled last

      clock = 1'b0;
      reset = 1'b1;
      addr = '0;
      wdata = '0;
      readmem = 1'b0;
      writemem = 1'b0;
      readio = 1'b0;
      writeio = 1'b0;
      inta = 1'b0;
      irq_lines = '0;
      m_boot = 1'b1;
      for (int i = 0; i < SEL_COUNT; i++) begin
         m_mask[i] = '0;
         m_comp[i] = '0;
      end
      repeat (5) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;

      // test 1 bootstrap state
      check_sel("sel", 4'b0011, sel);
      check_bit("bootstrap", 1'b1, bootstrap);
      check_bit("intr", 1'b0, intr);
      io_read(16'h0000, d);
      check_data("main", 8'h00, d);
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         a = r[15:0];          // any block since the shadow select is forced
         mem_write(a, r[23:16]);
         model_write(a[9:0], r[23:16]);
      end
      for (int i = 0; i < 8; i++) begin
         mem_read({6'd0, m_written[i]}, d);
         check_data("ram boot", 8'h00, d);   // rom space reads as zero
      end
      end_test("bootstrap");

      // test 2 select cells
      for (int i = 0; i < SEL_COUNT; i++) begin
         r = $random(seed);
         io_write(bus_addr_t'(2 * (i + 1) + 1), r[7:0]);   // compare first
         m_comp[i] = r[7:2];
      end
      for (int k = 0; k < SEL_COUNT; k++) begin
         r = $random(seed);
         io_write(bus_addr_t'(2 * (order[k] + 1)), r[7:0]);
         m_mask[order[k]] = r[7:0];
      end
      for (int i = 0; i < SEL_COUNT; i++) begin
         io_read(bus_addr_t'(2 * (i + 1)), d);
         check_data("cell mask", m_mask[i], d);
         io_read(bus_addr_t'(2 * (i + 1) + 1), d);
         check_data("cell compare", {m_comp[i], 2'b00}, d);
      end
      io_write(16'h0000, 8'h00);   // bootstrap off
      m_boot = 1'b0;
      check_bit("bootstrap", m_boot, bootstrap);
      for (int i = 0; i < 32; i++) begin
         r = $random(seed);
         @(negedge clock);
         addr = r[15:0];
         @(posedge clock);
         check_sel("sel", sel_model(addr), sel);
      end
      io_write(16'h0006, 8'h00);   // park cell 3 until the controller test
      m_mask[2] = '0;
      end_test("select");

      // test 3 ram in block 0
      io_write(16'h0004, 8'hFD);   // full mask, memory, enabled
      io_write(16'h0005, 8'h00);
      m_mask[1] = 8'hFD;
      m_comp[1] = '0;
      for (int i = 0; i < 24; i++) begin
         r = $random(seed);
         mem_write({6'd0, r[9:0]}, r[17:10]);
         model_write(r[9:0], r[17:10]);
      end
      for (int i = 0; i < 24; i++) begin
         r = $random(seed);
         idx = (r & 32'h7fff_ffff) % m_written.size();
         mem_read({6'd0, m_written[idx]}, d);
         check_data("ram", m_mem[m_written[idx]], d);
      end
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         a = r[15:0];
         if (a[15:10] == 6'd0) a[15:10] = 6'd1;   // stay outside block 0
         mem_read(a, d);
         check_data("ram outside", 8'h00, d);
      end
      end_test("ram");

      // test 4 moves the selector window to 0x50
      io_write(16'h0000, 8'h50);
      check_bit("bootstrap", m_boot, bootstrap);
      io_read(16'h0050, d);
      check_data("main", 8'h50, d);
      io_read(16'h0054, d);
      check_data("cell mask", m_mask[1], d);
      io_read(16'h0055, d);
      check_data("cell compare", 8'h00, d);
      io_read(16'h0004, d);
      check_data("old window", 8'h00, d);
      io_read(16'h0000, d);
      check_data("old main", 8'h00, d);
      end_test("relocate");

      // test 5 controller at i/o 0x80..0x87 on select 3
      io_write(16'h0057, 8'h80);
      io_write(16'h0056, 8'hFB);   // mask 111110, i/o, enabled
      m_comp[2] = 6'h20;
      m_mask[2] = 8'hFB;
      for (int i = 0; i < 8; i++) begin
         clear_int();
         r = $random(seed);
         e = r[7:0];
         p = r[15:8];
         m = r[23:16];
         l0 = r[31:24];
         r = $random(seed);
         l1 = r[7:0];
         io_write(16'h0084, e);
         io_write(16'h0083, p);
         irq_lines = l0;
         idle(3);
         io_write(16'h0082, 8'h00);
         io_read(16'h0082, d);
         check_data("active clear", 8'h00, d);
         io_write(16'h0080, m);
         irq_lines = l1;          // first edge with the new mask sees l1
         act = m & ((~e & ~(l1 ^ p))
                  | (e & p & l1 & ~l0)
                  | (e & ~p & ~l1 & l0));
         idle(3);
         io_read(16'h0081, d);
         check_data("status", l1, d);
         io_read(16'h0082, d);
         check_data("active", act, d);
         check_bit("intr", |act, intr);
         io_read(16'h0080, d);
         check_data("int mask", m, d);
         io_read(16'h0083, d);
         check_data("polarity", p, d);
         io_read(16'h0084, d);
         check_data("edge", e, d);
      end
      end_test("interrupts");

      // test 6 call vector sequence
      for (int round = 0; round < 2; round++) begin
         clear_int();
         irq_lines = '0;
         r = $random(seed);
         v = r[7:0];
         act = r[15:8];
         if (act == '0) act = 8'h81;
         io_write(16'h0085, v);
         io_write(16'h0082, act);
         idle(1);
         check_bit("intr", 1'b1, intr);
         while (act != '0) begin
            idx = 0;
            for (int j = 7; j >= 0; j--) begin
               if (act[j]) idx = j;   // lowest line wins
            end
            acknowledge(d);
            check_data("vector call", 8'hCD, d);
            acknowledge(d);
            check_data("vector low", bus_data_t'(idx * 4), d);
            acknowledge(d);
            check_data("vector high", v, d);
            act = act & ~(irq_vec_t'(1) << idx);
            io_read(16'h0082, d);
            check_data("active", act, d);
            check_bit("intr", |act, intr);
         end
      end
      end_test("vectoring");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
